/* rtl/csi_lvds_params.svh */
`ifndef CSI_LVDS_PARAMS_SVH
`define CSI_LVDS_PARAMS_SVH

// ------------------------------------------------------------
// CSI-2 receive side
// ------------------------------------------------------------

`define CSI_DATA_W      64  // Payload beat width
`define CSI_BYTES       8   // Bytes per beat
`define CSI_WC_W        16  // Long packet word count width
`define CSI_PAD_IDX     3   // Lines padded to 2**3 bytes

// ------------------------------------------------------------
// LVDS transmit side
// ------------------------------------------------------------

`define LVDS_RDY_STAGES 2   // Ready synchronizer depth

// Training pattern sent until the far end reports ready
`define LVDS_CAL_WORD   71'h55_FEDC_BA98_7654_3210

`endif

/* rtl/csi_lvds_pkg.sv */
`include "csi_lvds_params.svh"

package csi_lvds_pkg;

  // ------------------------------------------------------------
  // CSI-2 packet fields
  // ------------------------------------------------------------

  typedef enum logic [5:0] {
    DT_FRAME_START = 6'h00,
    DT_FRAME_END   = 6'h01,
    DT_EMBEDDED    = 6'h12  // Embedded 8-bit non-image data
  } csi_dt_e;

  typedef struct packed {
    csi_dt_e               dt;
    logic [1:0]            vc;
    logic [`CSI_WC_W-1:0]  wc;  // Bytes in the long packet
  } csi_hdr_t;

  typedef struct packed {
    logic [`CSI_DATA_W-1:0] data;
    logic [`CSI_BYTES-1:0]  bytevld;  // One bit per byte lane
  } csi_payload_t;

  // ------------------------------------------------------------
  // Internal beat and LVDS word
  // ------------------------------------------------------------

  typedef struct packed {
    logic [1:0] vc;
    logic       line_end;
    logic       embedded;
  } beat_user_t;

  typedef struct packed {
    logic                   valid;
    logic                   last;  // Frame end
    beat_user_t             user;
    logic [`CSI_BYTES-1:0]  keep;
    logic [`CSI_DATA_W-1:0] data;
  } axis_beat_t;

  typedef enum logic [2:0] {
    META_IDLE   = 3'd0,
    META_DATA   = 3'd1,
    META_LAST_8 = 3'd2,
    META_LAST_6 = 3'd3,
    META_LAST_4 = 3'd4,
    META_LAST_2 = 3'd5,
    META_LAST_0 = 3'd6
  } lvds_meta_e;

  typedef struct packed {
    beat_user_t             user;
    lvds_meta_e             meta;
    logic [`CSI_DATA_W-1:0] data;
  } lvds_word_t;

  typedef enum logic [1:0] {
    LINE_IDLE = 2'd0,
    LINE_DATA = 2'd1,
    LINE_PAD  = 2'd2
  } line_state_e;

endpackage

/* rtl/csi_payload_stage.sv */
`timescale 1ns/10ps
`include "csi_lvds_params.svh"

module csi_payload_stage
  import csi_lvds_pkg::*;
(
  input  logic         clk_25,
  input  logic         lvds_rst,
  input  logic         payload_en_i,
  input  csi_payload_t payload_i,
  output csi_payload_t payload_o,
  output logic         payload_en_o
);

  logic [`CSI_DATA_W-1:0] data_masked;
  logic [`CSI_BYTES:0]    vld_ext;  // Extra bit so all-ones does not wrap

  always_comb begin
    for (int b = 0; b < `CSI_BYTES; b++) begin
      data_masked[b*8 +: 8] = payload_i.bytevld[b] ? payload_i.data[b*8 +: 8] : 8'h00;
    end
  end

  assign vld_ext = {1'b0, payload_i.bytevld};

  always_ff @(posedge clk_25 or posedge lvds_rst) begin
    if (lvds_rst) begin
      payload_en_o <= 1'b0;
    end else begin
      payload_en_o <= payload_en_i;
    end
  end

  always_ff @(posedge clk_25) begin
    payload_o.data    <= data_masked;  // Stale bytes cleared
    payload_o.bytevld <= payload_i.bytevld;
  end

  // Byte lanes fill from lane 0 with no holes
  a_bytevld_contig: assert property (@(posedge clk_25) disable iff (lvds_rst)
    payload_en_i |-> (((vld_ext + 1'b1) & vld_ext) == '0))
    else $error("bytevld not contiguous from lane 0: %b", payload_i.bytevld);

endmodule

/* rtl/csi_line_ctrl.sv */
`timescale 1ns/10ps
`include "csi_lvds_params.svh"

module csi_line_ctrl
  import csi_lvds_pkg::*;
(
  input  logic         clk_25,
  input  logic         lvds_rst,
  input  logic         sp_en_i,
  input  logic         payload_en_i,
  input  csi_hdr_t     hdr_i,
  input  logic         payload_en_q_i,
  input  csi_payload_t payload_q_i,
  output axis_beat_t   beat_o
);

  localparam int STEP_W = $clog2(`CSI_BYTES) + 1;
  localparam int CNT_W  = `CSI_WC_W + 1;  // Headroom for the final step
  localparam int UNIT_W = `CSI_WC_W - `CSI_PAD_IDX;

  line_state_e            state;
  logic                   in_frame;
  logic                   fe_q;        // Frame end seen inside a frame
  logic [1:0]             fe_vc_q;
  logic                   first_q;     // Next payload beat opens the line
  logic [1:0]             vc_q;
  logic                   embedded_q;
  logic [`CSI_WC_W-1:0]   wc_pad_q;
  logic [`CSI_BYTES-1:0]  keep_q;      // Keep of the first beat
  logic [CNT_W-1:0]       byte_cnt;

  logic                   frame_start;
  logic                   frame_end;
  logic                   line_start;
  logic [UNIT_W-1:0]      wc_units;
  logic [`CSI_WC_W-1:0]   wc_pad;
  logic [STEP_W-1:0]      step_cur;
  logic [CNT_W-1:0]       cnt_nxt;
  logic                   line_done;
  axis_beat_t             beat_nxt;

  // Index of the highest valid lane plus one
  function automatic logic [STEP_W-1:0] valid_bytes(input logic [`CSI_BYTES-1:0] kv);
    logic [STEP_W-1:0] n;
    n = '0;
    for (int i = 0; i < `CSI_BYTES; i++) begin
      if (kv[i]) begin
        n = STEP_W'(i + 1);
      end
    end
    return n;
  endfunction

  // ------------------------------------------------------------
  // Packet decode
  // ------------------------------------------------------------

  assign frame_start = sp_en_i && (hdr_i.dt == DT_FRAME_START);
  assign frame_end   = sp_en_i && (hdr_i.dt == DT_FRAME_END);
  assign line_start  = payload_en_i && !payload_en_q_i;  // Rising payload enable

  // Word count rounded up to the padding granule
  assign wc_units = hdr_i.wc[`CSI_WC_W-1:`CSI_PAD_IDX]
                  + UNIT_W'(|hdr_i.wc[`CSI_PAD_IDX-1:0]);
  assign wc_pad   = {wc_units, {`CSI_PAD_IDX{1'b0}}};

  // Every beat of a line advances the count by the step
  assign step_cur  = valid_bytes(first_q ? payload_q_i.bytevld : keep_q);
  assign cnt_nxt   = byte_cnt + CNT_W'(step_cur);
  assign line_done = (cnt_nxt >= CNT_W'(wc_pad_q));

  // ------------------------------------------------------------
  // Beat selection
  // ------------------------------------------------------------

  always_comb begin
    beat_nxt = '0;
    if (fe_q) begin
      beat_nxt.valid   = 1'b1;  // Frame end marker, no payload
      beat_nxt.last    = 1'b1;
      beat_nxt.user.vc = fe_vc_q;
    end else if (in_frame && payload_en_q_i && (state == LINE_DATA)) begin
      beat_nxt.valid         = 1'b1;
      beat_nxt.user.vc       = vc_q;
      beat_nxt.user.line_end = line_done;
      beat_nxt.user.embedded = embedded_q;
      beat_nxt.keep          = payload_q_i.bytevld;
      beat_nxt.data          = payload_q_i.data;
    end else if (in_frame && (state == LINE_PAD)) begin
      beat_nxt.valid         = 1'b1;  // Zero filler up to the granule
      beat_nxt.user.vc       = vc_q;
      beat_nxt.user.line_end = line_done;
      beat_nxt.user.embedded = embedded_q;
      beat_nxt.keep          = keep_q;
    end
  end

  // ------------------------------------------------------------
  // Frame and line state
  // ------------------------------------------------------------

  always_ff @(posedge clk_25 or posedge lvds_rst) begin
    if (lvds_rst) begin
      state    <= LINE_IDLE;
      in_frame <= 1'b0;
      fe_q     <= 1'b0;
      first_q  <= 1'b0;
      byte_cnt <= '0;
      beat_o   <= '0;
    end else begin
      beat_o <= beat_nxt;
      fe_q   <= frame_end && in_frame;
      if (frame_start) begin
        in_frame <= 1'b1;
      end else if (frame_end) begin
        in_frame <= 1'b0;
      end
      if (line_start) begin
        state    <= LINE_DATA;
        first_q  <= 1'b1;
        byte_cnt <= '0;
      end else begin
        case (state)
          LINE_DATA: begin
            if (payload_en_q_i) begin
              first_q  <= 1'b0;
              byte_cnt <= cnt_nxt;
              if (!payload_en_i) begin  // Last payload beat
                state <= line_done ? LINE_IDLE : LINE_PAD;
              end
            end
          end
          LINE_PAD: begin
            byte_cnt <= cnt_nxt;
            if (line_done) begin
              state <= LINE_IDLE;
            end
          end
          default: begin
            byte_cnt <= '0;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_25) begin
    if (line_start) begin
      vc_q       <= hdr_i.vc;
      embedded_q <= (hdr_i.dt == DT_EMBEDDED);
      wc_pad_q   <= wc_pad;
    end
    if (first_q && payload_en_q_i) begin
      keep_q <= payload_q_i.bytevld;
    end
    if (frame_end) begin
      fe_vc_q <= hdr_i.vc;
    end
  end

  // The source must wait out the pad beats before the next line
  a_no_start_in_pad: assert property (@(posedge clk_25) disable iff (lvds_rst)
    line_start |-> (state != LINE_PAD))
    else $error("payload_en_i rose while line padding was active");

  a_pad_step: assert property (@(posedge clk_25) disable iff (lvds_rst)
    (state == LINE_PAD) |-> (step_cur != '0))
    else $error("padding with a zero byte step");

endmodule

/* rtl/lvds_word_fmt.sv */
`timescale 1ns/10ps
`include "csi_lvds_params.svh"

module lvds_word_fmt
  import csi_lvds_pkg::*;
(
  input  logic       clk_25,
  input  logic       lvds_rst,
  input  logic       lvds_rdy_i,
  input  axis_beat_t beat_i,
  output lvds_word_t lvds_word_o
);

  logic [`LVDS_RDY_STAGES-1:0] rdy_sync;
  logic                        rdy_s;
  lvds_meta_e                  meta;

  // ------------------------------------------------------------
  // Ready synchronizer
  // ------------------------------------------------------------

  always_ff @(posedge clk_25 or posedge lvds_rst) begin
    if (lvds_rst) begin
      rdy_sync <= '0;
    end else begin
      rdy_sync <= {rdy_sync[`LVDS_RDY_STAGES-2:0], lvds_rdy_i};
    end
  end

  assign rdy_s = rdy_sync[`LVDS_RDY_STAGES-1];

  // Padded lines leave only even byte counts on a last beat
  always_comb begin
    if (!beat_i.valid) begin
      meta = META_IDLE;
    end else if (!beat_i.last) begin
      meta = META_DATA;
    end else if (beat_i.keep[7]) begin
      meta = META_LAST_8;
    end else if (beat_i.keep[5]) begin
      meta = META_LAST_6;
    end else if (beat_i.keep[3]) begin
      meta = META_LAST_4;
    end else if (beat_i.keep[1]) begin
      meta = META_LAST_2;
    end else begin
      meta = META_LAST_0;
    end
  end

  always_ff @(posedge clk_25 or posedge lvds_rst) begin
    if (lvds_rst) begin
      lvds_word_o <= `LVDS_CAL_WORD;
    end else if (!rdy_s) begin
      lvds_word_o <= `LVDS_CAL_WORD;  // Keep the link trained
    end else begin
      lvds_word_o.user <= beat_i.user;
      lvds_word_o.meta <= meta;
      lvds_word_o.data <= beat_i.data;
    end
  end

endmodule

/* rtl/csi_lvds_bridge.sv */
`timescale 1ns/10ps

module csi_lvds_bridge
  import csi_lvds_pkg::*;
(
  input  logic         clk_25,
  input  logic         lvds_rst,
  input  logic         sp_en_i,       // Short packet strobe
  input  logic         payload_en_i,  // High across a long packet
  input  csi_hdr_t     hdr_i,
  input  csi_payload_t payload_i,
  input  logic         lvds_rdy_i,    // Asynchronous
  output lvds_word_t   lvds_word_o
);

  csi_payload_t payload_q;
  logic         payload_en_q;
  axis_beat_t   beat;

  // ------------------------------------------------------------
  // CSI-2 to beat
  // ------------------------------------------------------------

  csi_payload_stage csi_payload_stage_inst (
    .clk_25       (clk_25),
    .lvds_rst     (lvds_rst),
    .payload_en_i (payload_en_i),
    .payload_i    (payload_i),
    .payload_o    (payload_q),
    .payload_en_o (payload_en_q)
  );

  csi_line_ctrl csi_line_ctrl_inst (
    .clk_25         (clk_25),
    .lvds_rst       (lvds_rst),
    .sp_en_i        (sp_en_i),
    .payload_en_i   (payload_en_i),
    .hdr_i          (hdr_i),
    .payload_en_q_i (payload_en_q),
    .payload_q_i    (payload_q),
    .beat_o         (beat)
  );

  // ------------------------------------------------------------
  // Beat to LVDS word
  // ------------------------------------------------------------

  lvds_word_fmt lvds_word_fmt_inst (
    .clk_25      (clk_25),
    .lvds_rst    (lvds_rst),
    .lvds_rdy_i  (lvds_rdy_i),
    .beat_i      (beat),
    .lvds_word_o (lvds_word_o)
  );

endmodule

/* dv/tb_csi_lvds_tests.svh */
`ifndef TB_CSI_LVDS_TESTS_SVH
`define TB_CSI_LVDS_TESTS_SVH

localparam csi_dt_e DT_RAW8 = csi_dt_e'(6'h2A);  // Plain image line

// ------------------------------------------------------------
// Stimulus and reference model
// ------------------------------------------------------------

task automatic send_short(input csi_dt_e dt, input logic [1:0] vc);
  lvds_word_t w;
  @(negedge clk_25);
  sp_en_i  = 1'b1;
  hdr_i.dt = dt;
  hdr_i.vc = vc;
  hdr_i.wc = '0;
  @(negedge clk_25);
  sp_en_i = 1'b0;
  if (dt == DT_FRAME_START) begin
    model_in_frame = 1'b1;
  end else if (dt == DT_FRAME_END) begin
    w         = '0;  // Empty marker beat
    w.user.vc = vc;
    w.meta    = META_LAST_0;
    if (model_in_frame) begin
      exp_q.push_back(w);
    end
    model_in_frame = 1'b0;
  end
endtask

task automatic send_line(input csi_dt_e dt, input logic [1:0] vc, input int wc, input int nbeats,
                         input logic [7:0] step_vld, input logic [7:0] tail_vld);
  csi_payload_t pl;
  lvds_word_t   w;
  logic [63:0]  lane_mask;
  int           step;
  int           target;
  int           total;
  step   = $countones(step_vld);
  target = ((wc + 7) / 8) * 8;  // Whole 8-byte granules
  total  = 0;
  w      = '0;
  for (int i = 0; i < nbeats; i++) begin
    @(negedge clk_25);
    pl.data      = {$random(seed), $random(seed)};
    pl.bytevld   = (i == nbeats - 1) ? tail_vld : step_vld;
    payload_en_i = 1'b1;
    hdr_i.dt     = dt;
    hdr_i.vc     = vc;
    hdr_i.wc     = 16'(wc);
    payload_i    = pl;
    total += step;
    w.user.vc       = vc;
    w.user.embedded = (dt == DT_EMBEDDED);
    w.user.line_end = (total >= target);
    w.meta          = META_DATA;
    // Valid lanes fill from lane 0
    lane_mask = {64{1'b1}} >> (64 - 8 * $countones(pl.bytevld));
    w.data    = pl.data & lane_mask;
    if (model_in_frame) begin
      exp_q.push_back(w);
    end
  end
  @(negedge clk_25);
  payload_en_i = 1'b0;
  payload_i    = '0;
  while (total < target) begin
    total += step;  // Zero filler beats
    w.data          = '0;
    w.user.line_end = (total >= target);
    if (model_in_frame) begin
      exp_q.push_back(w);
    end
  end
  repeat (12) @(negedge clk_25);
endtask

task automatic compare_output(input string label);
  lvds_word_t exp;
  lvds_word_t act;
  int         waited;
  waited = 0;
  while ((got_q.size() < exp_q.size()) && (waited < 200)) begin
    @(negedge clk_25);
    waited++;
  end
  if (got_q.size() < exp_q.size()) begin
    err_cnt++;
    $display("timeout at %0t: %s got %0d of %0d words", $time, label, got_q.size(),
             exp_q.size());
  end
  while ((exp_q.size() > 0) && (got_q.size() > 0)) begin
    exp = exp_q.pop_front();
    act = got_q.pop_front();
    check_meta("lvds_word_o.meta", exp.meta, act.meta);
    check_word("lvds_word_o", exp, act);
  end
  if (got_q.size() != 0) begin
    err_cnt++;
    $display("%s: %0d unexpected words on lvds_word_o", label, got_q.size());
  end
  exp_q.delete();
  got_q.delete();
endtask

// ------------------------------------------------------------
// Directed tests
// ------------------------------------------------------------

task automatic test_ready_switch();
  int waited;
  repeat (4) @(negedge clk_25);
  check_word("lvds_word_o", lvds_word_t'(`LVDS_CAL_WORD), lvds_word_o);
  lvds_rdy_i = 1'b1;
  waited     = 0;
  while ((lvds_word_o == `LVDS_CAL_WORD) && (waited < 20)) begin
    @(negedge clk_25);
    waited++;
  end
  if (lvds_word_o == `LVDS_CAL_WORD) begin
    err_cnt++;
    $display("timeout at %0t: lvds_word_o kept the calibration word after ready", $time);
  end else begin
    check_word("lvds_word_o", lvds_word_t'('0), lvds_word_o);  // Idle link
  end
  finish_test("ready_switch");
endtask

task automatic test_full_line();
  send_short(DT_FRAME_START, 2'd1);
  send_line(DT_RAW8, 2'd1, 32, 4, 8'hFF, 8'hFF);
  send_short(DT_FRAME_END, 2'd1);
  compare_output("full_line");
  finish_test("full_line");
endtask

task automatic test_partial_tail();
  send_short(DT_FRAME_START, 2'd0);
  send_line(DT_RAW8, 2'd0, 19, 3, 8'hFF, 8'h07);  // 3 bytes in the last beat
  send_short(DT_FRAME_END, 2'd0);
  compare_output("partial_tail");
  finish_test("partial_tail");
endtask

task automatic test_pad_line();
  send_short(DT_FRAME_START, 2'd3);
  send_line(DT_RAW8, 2'd3, 20, 5, 8'h0F, 8'h0F);
  send_short(DT_FRAME_END, 2'd3);
  compare_output("pad_line");
  finish_test("pad_line");
endtask

task automatic test_embedded_and_outside();
  send_short(DT_FRAME_START, 2'd2);
  send_line(DT_EMBEDDED, 2'd2, 16, 2, 8'hFF, 8'hFF);
  send_short(DT_FRAME_END, 2'd2);
  compare_output("embedded_line");
  send_line(DT_RAW8, 2'd1, 16, 2, 8'hFF, 8'hFF);  // No frame open
  compare_output("outside_frame");
  finish_test("embedded_and_outside");
endtask

`endif

/* dv/tb_csi_lvds_bridge.sv */
`timescale 1ns/10ps
`include "csi_lvds_params.svh"

module tb_csi_lvds_bridge
  import csi_lvds_pkg::*;
();

  logic         clk_25;
  logic         lvds_rst;
  logic         sp_en_i;
  logic         payload_en_i;
  csi_hdr_t     hdr_i;
  csi_payload_t payload_i;
  logic         lvds_rdy_i;
  lvds_word_t   lvds_word_o;

  lvds_word_t   got_q[$];  // Words seen on the link
  lvds_word_t   exp_q[$];  // Words the rules predict
  integer       seed = 32'h04e8_66c0;
  bit           model_in_frame;
  int           err_cnt;
  int           err_base;
  int           test_cnt;
  int           fail_cnt;
  int           check_cnt;

  always #10 clk_25 = ~clk_25;

  csi_lvds_bridge csi_lvds_bridge_inst (
    .clk_25       (clk_25),
    .lvds_rst     (lvds_rst),
    .sp_en_i      (sp_en_i),
    .payload_en_i (payload_en_i),
    .hdr_i        (hdr_i),
    .payload_i    (payload_i),
    .lvds_rdy_i   (lvds_rdy_i),
    .lvds_word_o  (lvds_word_o)
  );

  // Registered output is settled by the falling edge
  always @(negedge clk_25) begin
    if (!lvds_rst && (lvds_word_o.meta != META_IDLE) && (lvds_word_o != `LVDS_CAL_WORD)) begin
      got_q.push_back(lvds_word_o);
    end
  end

  // ------------------------------------------------------------
  task automatic check_word(input string name, input lvds_word_t exp, input lvds_word_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_meta(input string name, input lvds_meta_e exp, input lvds_meta_e act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("mismatch at %0t: %s expected %s actual %s (%0d)", $time, name, exp.name(),
               act.name(), act);
    end
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    if (err_cnt == err_base) begin
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, err_cnt - err_base);
    end
    err_base = err_cnt;
  endtask

  `include "tb_csi_lvds_tests.svh"

  initial begin
    clk_25       = 1'b0;
    lvds_rst     = 1'b1;
    sp_en_i      = 1'b0;
    payload_en_i = 1'b0;
    hdr_i        = '0;
    payload_i    = '0;
    lvds_rdy_i   = 1'b0;
    repeat (16) @(posedge clk_25);
    @(negedge clk_25);
    lvds_rst = 1'b0;
    test_ready_switch();
    test_full_line();
    test_partial_tail();
    test_pad_line();
    test_embedded_and_outside();
    $display("%0d tests, %0d failed, %0d checks, %0d errors", test_cnt, fail_cnt, check_cnt,
             err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+rtl
+incdir+dv
rtl/csi_lvds_pkg.sv
rtl/csi_payload_stage.sv
rtl/csi_line_ctrl.sv
rtl/lvds_word_fmt.sv
rtl/csi_lvds_bridge.sv
dv/tb_csi_lvds_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_csi_lvds_bridge -o sim_csi_lvds_bridge \
  && ./obj_dir/sim_csi_lvds_bridge > sim.log 2>&1
cat sim.log 2>/dev/null

grep -qx "Verification passed" sim.log && exit 0 || exit 1
